//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN = 64;
	localparam int NUM_GPR = 32;

	typedef logic [XLEN-1:0] xlen_t; // Machine word for pc, data and addresses
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_id_t;
	typedef logic [14:0] op_class_t; // One-hot class from decode
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	// Classes 0, 1, 2, 5, 7, 8, 9, 10 and 11 produce a value for rd
	localparam op_class_t OP_WRITES_RD = 15'b000_1111_1010_0111;

	localparam opcode_t OPCODE_LOAD = 7'b0000011;
	localparam opcode_t OPCODE_STORE = 7'b0100011;

	// Load widths, signed and unsigned
	localparam funct3_t FUNCT3_LB = 3'b000;
	localparam funct3_t FUNCT3_LH = 3'b001;
	localparam funct3_t FUNCT3_LW = 3'b010;
	localparam funct3_t FUNCT3_LD = 3'b011;
	localparam funct3_t FUNCT3_LBU = 3'b100;
	localparam funct3_t FUNCT3_LHU = 3'b101;
	localparam funct3_t FUNCT3_LWU = 3'b110;

	// Store widths
	localparam funct3_t FUNCT3_SB = 3'b000;
	localparam funct3_t FUNCT3_SH = 3'b001;
	localparam funct3_t FUNCT3_SW = 3'b010;
	localparam funct3_t FUNCT3_SD = 3'b011;

endpackage

`default_nettype wire

//--- hw/retire_pkg.sv
`default_nettype none

package retire_pkg;

	// Access kind carried in each retire record
	// The codes follow the trace convention of 0 none, 1 load and 2 store
	typedef enum logic [1:0] {
		MEM_NONE = 2'd0,
		MEM_LOAD = 2'd1,
		MEM_STORE = 2'd2
	} mem_kind_t;

endpackage

`default_nettype wire

//--- hw/wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
	input wire clk,
	input wire rst,
	input wire advance,
	input wire in_valid,
	input wire rv_isa_pkg::xlen_t in_pc,
	input wire rv_isa_pkg::inst_t in_inst,
	input wire rv_isa_pkg::op_class_t in_op_class,
	input wire rv_isa_pkg::reg_id_t in_rd,
	input wire rv_isa_pkg::xlen_t in_wdata,
	input wire rv_isa_pkg::xlen_t in_raddr,
	input wire rv_isa_pkg::xlen_t in_waddr,
	output logic wb_valid,
	output rv_isa_pkg::xlen_t wb_pc,
	output rv_isa_pkg::inst_t wb_inst,
	output rv_isa_pkg::xlen_t wb_raddr,
	output rv_isa_pkg::xlen_t wb_waddr,
	output logic gpr_we,
	output rv_isa_pkg::reg_id_t gpr_waddr,
	output rv_isa_pkg::xlen_t gpr_wdata
);

	rv_isa_pkg::op_class_t held_class;
	rv_isa_pkg::reg_id_t held_rd;
	rv_isa_pkg::xlen_t held_wdata;
	logic writes_rd;

	// The valid bit follows the upstream strobe only when the pipe moves
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else if (advance) begin
			wb_valid <= in_valid;
		end
	end

	// Payload is captured on every advance, valid or not
	always_ff @(posedge clk) begin
		if (advance) begin
			wb_pc <= in_pc;
			wb_inst <= in_inst;
			held_class <= in_op_class;
			held_rd <= in_rd;
			held_wdata <= in_wdata;
			wb_raddr <= in_raddr;
			wb_waddr <= in_waddr;
		end
	end

	assign writes_rd = |(held_class & rv_isa_pkg::OP_WRITES_RD);

	// A frozen instruction stays in the register for several cycles, so the
	// write is only released on the cycle that the pipe moves on
	assign gpr_we = wb_valid && writes_rd && advance;
	assign gpr_waddr = held_rd;
	assign gpr_wdata = held_wdata; // x0 filtering is left to the register file

endmodule

`default_nettype wire

//--- hw/gpr_file.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_file (
	input wire clk,
	input wire rst,
	input wire we,
	input wire rv_isa_pkg::reg_id_t waddr,
	input wire rv_isa_pkg::xlen_t wdata,
	input wire rv_isa_pkg::reg_id_t rs1,
	input wire rv_isa_pkg::reg_id_t rs2,
	output rv_isa_pkg::xlen_t rs1_data,
	output rv_isa_pkg::xlen_t rs2_data
);

	// Only x1 to x31 have storage
	rv_isa_pkg::xlen_t regs [1:rv_isa_pkg::NUM_GPR-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < rv_isa_pkg::NUM_GPR; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle writes are not forwarded, a read sees the value after the edge
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hw/retire_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module retire_monitor #(
	parameter int COUNT_WIDTH = 32 // At least 8, all counters wrap
) (
	input wire clk,
	input wire rst,
	input wire advance,
	input wire wb_valid,
	input wire rv_isa_pkg::xlen_t wb_pc,
	input wire rv_isa_pkg::inst_t wb_inst,
	input wire rv_isa_pkg::xlen_t wb_raddr,
	input wire rv_isa_pkg::xlen_t wb_waddr,
	output logic retire_valid,
	output rv_isa_pkg::xlen_t retire_pc,
	output rv_isa_pkg::inst_t retire_inst,
	output retire_pkg::mem_kind_t retire_mem_kind,
	output rv_isa_pkg::xlen_t retire_mem_addr,
	output logic [COUNT_WIDTH-1:0] retire_count,
	output logic [COUNT_WIDTH-1:0] load_count,
	output logic [COUNT_WIDTH-1:0] store_count
);

	logic commit;
	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::funct3_t funct3;
	retire_pkg::mem_kind_t kind;
	rv_isa_pkg::xlen_t mem_addr;

	assign commit = wb_valid && advance;
	assign opcode = wb_inst[6:0];
	assign funct3 = wb_inst[14:12];

	// Only the legal width encodings count as memory accesses
	always_comb begin
		case ({funct3, opcode})
			{rv_isa_pkg::FUNCT3_LB, rv_isa_pkg::OPCODE_LOAD},
			{rv_isa_pkg::FUNCT3_LH, rv_isa_pkg::OPCODE_LOAD},
			{rv_isa_pkg::FUNCT3_LW, rv_isa_pkg::OPCODE_LOAD},
			{rv_isa_pkg::FUNCT3_LD, rv_isa_pkg::OPCODE_LOAD},
			{rv_isa_pkg::FUNCT3_LBU, rv_isa_pkg::OPCODE_LOAD},
			{rv_isa_pkg::FUNCT3_LHU, rv_isa_pkg::OPCODE_LOAD},
			{rv_isa_pkg::FUNCT3_LWU, rv_isa_pkg::OPCODE_LOAD}: begin
				kind = retire_pkg::MEM_LOAD;
				mem_addr = wb_raddr;
			end
			{rv_isa_pkg::FUNCT3_SB, rv_isa_pkg::OPCODE_STORE},
			{rv_isa_pkg::FUNCT3_SH, rv_isa_pkg::OPCODE_STORE},
			{rv_isa_pkg::FUNCT3_SW, rv_isa_pkg::OPCODE_STORE},
			{rv_isa_pkg::FUNCT3_SD, rv_isa_pkg::OPCODE_STORE}: begin
				kind = retire_pkg::MEM_STORE;
				mem_addr = wb_waddr;
			end
			default: begin
				kind = retire_pkg::MEM_NONE;
				mem_addr = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			retire_count <= '0;
			load_count <= '0;
			store_count <= '0;
		end else begin
			retire_valid <= commit; // One pulse per commit edge
			if (commit) begin
				retire_count <= retire_count + 1'b1;
				if (kind == retire_pkg::MEM_LOAD) begin
					load_count <= load_count + 1'b1;
				end
				if (kind == retire_pkg::MEM_STORE) begin
					store_count <= store_count + 1'b1;
				end
			end
		end
	end

	// Record fields are only meaningful while retire_valid is high
	always_ff @(posedge clk) begin
		if (commit) begin
			retire_pc <= wb_pc;
			retire_inst <= wb_inst;
			retire_mem_kind <= kind;
			retire_mem_addr <= mem_addr;
		end
	end

endmodule

`default_nettype wire

//--- hw/writeback_top.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_top #(
	parameter int COUNT_WIDTH = 32
) (
	input wire clk,
	input wire rst,
	input wire advance,
	input wire in_valid,
	input wire rv_isa_pkg::xlen_t in_pc,
	input wire rv_isa_pkg::inst_t in_inst,
	input wire rv_isa_pkg::op_class_t in_op_class,
	input wire rv_isa_pkg::reg_id_t in_rd,
	input wire rv_isa_pkg::xlen_t in_wdata,
	input wire rv_isa_pkg::xlen_t in_raddr,
	input wire rv_isa_pkg::xlen_t in_waddr,
	input wire rv_isa_pkg::reg_id_t rs1,
	input wire rv_isa_pkg::reg_id_t rs2,
	output rv_isa_pkg::xlen_t rs1_data,
	output rv_isa_pkg::xlen_t rs2_data,
	output logic retire_valid,
	output rv_isa_pkg::xlen_t retire_pc,
	output rv_isa_pkg::inst_t retire_inst,
	output retire_pkg::mem_kind_t retire_mem_kind,
	output rv_isa_pkg::xlen_t retire_mem_addr,
	output logic [COUNT_WIDTH-1:0] retire_count,
	output logic [COUNT_WIDTH-1:0] load_count,
	output logic [COUNT_WIDTH-1:0] store_count
);

	// Held instruction as seen by the monitor
	logic wb_valid;
	rv_isa_pkg::xlen_t wb_pc;
	rv_isa_pkg::inst_t wb_inst;
	rv_isa_pkg::xlen_t wb_raddr;
	rv_isa_pkg::xlen_t wb_waddr;

	// Write port of the register file
	logic gpr_we;
	rv_isa_pkg::reg_id_t gpr_waddr;
	rv_isa_pkg::xlen_t gpr_wdata;

	wb_stage i_wb_stage (
		.clk (clk),
		.rst (rst),
		.advance (advance),
		.in_valid (in_valid),
		.in_pc (in_pc),
		.in_inst (in_inst),
		.in_op_class (in_op_class),
		.in_rd (in_rd),
		.in_wdata (in_wdata),
		.in_raddr (in_raddr),
		.in_waddr (in_waddr),
		.wb_valid (wb_valid),
		.wb_pc (wb_pc),
		.wb_inst (wb_inst),
		.wb_raddr (wb_raddr),
		.wb_waddr (wb_waddr),
		.gpr_we (gpr_we),
		.gpr_waddr (gpr_waddr),
		.gpr_wdata (gpr_wdata)
	);

	gpr_file i_gpr_file (
		.clk (clk),
		.rst (rst),
		.we (gpr_we),
		.waddr (gpr_waddr),
		.wdata (gpr_wdata),
		.rs1 (rs1),
		.rs2 (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	retire_monitor #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) i_retire_monitor (
		.clk (clk),
		.rst (rst),
		.advance (advance),
		.wb_valid (wb_valid),
		.wb_pc (wb_pc),
		.wb_inst (wb_inst),
		.wb_raddr (wb_raddr),
		.wb_waddr (wb_waddr),
		.retire_valid (retire_valid),
		.retire_pc (retire_pc),
		.retire_inst (retire_inst),
		.retire_mem_kind (retire_mem_kind),
		.retire_mem_addr (retire_mem_addr),
		.retire_count (retire_count),
		.load_count (load_count),
		.store_count (store_count)
	);

endmodule

`default_nettype wire

//--- test/writeback_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_assertions #(
	parameter int COUNT_WIDTH = 32
) (
	input wire clk,
	input wire rst,
	input wire advance,
	input wire in_valid,
	input wire wb_valid,
	input wire gpr_we,
	input wire retire_valid,
	input wire [COUNT_WIDTH-1:0] retire_count,
	input wire [COUNT_WIDTH-1:0] load_count,
	input wire [COUNT_WIDTH-1:0] store_count,
	input wire rv_isa_pkg::reg_id_t rs1,
	input wire rv_isa_pkg::reg_id_t rs2,
	input wire rv_isa_pkg::xlen_t rs1_data,
	input wire rv_isa_pkg::xlen_t rs2_data
);

	int assert_failures = 0;

	// Upstream is frozen by the same stall
	a_no_input_when_frozen: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> advance)
		else begin
			assert_failures++;
			$error("in_valid high while advance is low");
		end

	// Back-to-back pulses come only from back-to-back instructions
	a_one_pulse_per_commit: assert property (@(posedge clk) disable iff (rst)
		(retire_valid && $past(retire_valid)) |-> $past(in_valid, 2))
		else begin
			assert_failures++;
			$error("retire_valid repeated without a new instruction");
		end

	a_reset_idle: assert property (@(posedge clk)
		$past(rst) |-> (!retire_valid && !wb_valid && !gpr_we && retire_count == '0
			&& load_count == '0 && store_count == '0))
		else begin
			assert_failures++;
			$error("outputs active after reset");
		end

	a_x0_port1: assert property (@(posedge clk) (rs1 == '0) |-> (rs1_data == '0))
		else begin
			assert_failures++;
			$error("x0 read nonzero on rs1");
		end

	a_x0_port2: assert property (@(posedge clk) (rs2 == '0) |-> (rs2_data == '0))
		else begin
			assert_failures++;
			$error("x0 read nonzero on rs2");
		end

endmodule

bind writeback_top writeback_assertions #(
	.COUNT_WIDTH (COUNT_WIDTH)
) i_writeback_assertions (
	.clk (clk),
	.rst (rst),
	.advance (advance),
	.in_valid (in_valid),
	.wb_valid (wb_valid),
	.gpr_we (gpr_we),
	.retire_valid (retire_valid),
	.retire_count (retire_count),
	.load_count (load_count),
	.store_count (store_count),
	.rs1 (rs1),
	.rs2 (rs2),
	.rs1_data (rs1_data),
	.rs2_data (rs2_data)
);

`default_nettype wire

//--- test/writeback_tb.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_tb;

	localparam int COUNT_WIDTH = 32;
	localparam int MAX_ROWS = 32;
	localparam int RESET_CYCLES = 16;
	localparam int RETIRE_TIMEOUT = 20; // Longest stall is 3 cycles
	localparam logic [31:0] LFSR_SEED = 32'h4ded;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	localparam rv_isa_pkg::opcode_t OPC_LOAD = 7'b0000011;
	localparam rv_isa_pkg::opcode_t OPC_STORE = 7'b0100011;
	localparam rv_isa_pkg::opcode_t OPC_OP = 7'b0110011;
	localparam rv_isa_pkg::opcode_t OPC_LUI = 7'b0110111;
	localparam rv_isa_pkg::opcode_t OPC_BRANCH = 7'b1100011;
	localparam rv_isa_pkg::opcode_t OPC_JAL = 7'b1101111;
	localparam rv_isa_pkg::opcode_t OPC_FENCE = 7'b0001111;

	localparam retire_pkg::mem_kind_t KIND_NONE = retire_pkg::MEM_NONE;
	localparam retire_pkg::mem_kind_t KIND_LOAD = retire_pkg::MEM_LOAD;
	localparam retire_pkg::mem_kind_t KIND_STORE = retire_pkg::MEM_STORE;

	logic clk = 1'b0;
	logic rst;
	logic advance;
	logic in_valid;
	rv_isa_pkg::xlen_t in_pc;
	rv_isa_pkg::inst_t in_inst;
	rv_isa_pkg::op_class_t in_op_class;
	rv_isa_pkg::reg_id_t in_rd;
	rv_isa_pkg::xlen_t in_wdata;
	rv_isa_pkg::xlen_t in_raddr;
	rv_isa_pkg::xlen_t in_waddr;
	rv_isa_pkg::reg_id_t rs1;
	rv_isa_pkg::reg_id_t rs2;
	rv_isa_pkg::xlen_t rs1_data;
	rv_isa_pkg::xlen_t rs2_data;
	logic retire_valid;
	rv_isa_pkg::xlen_t retire_pc;
	rv_isa_pkg::inst_t retire_inst;
	retire_pkg::mem_kind_t retire_mem_kind;
	rv_isa_pkg::xlen_t retire_mem_addr;
	logic [COUNT_WIDTH-1:0] retire_count;
	logic [COUNT_WIDTH-1:0] load_count;
	logic [COUNT_WIDTH-1:0] store_count;

	// Stimulus table, one entry per instruction
	rv_isa_pkg::xlen_t row_pc [MAX_ROWS];
	rv_isa_pkg::inst_t row_inst [MAX_ROWS];
	rv_isa_pkg::op_class_t row_class [MAX_ROWS];
	rv_isa_pkg::reg_id_t row_rd [MAX_ROWS];
	rv_isa_pkg::xlen_t row_raddr [MAX_ROWS];
	rv_isa_pkg::xlen_t row_waddr [MAX_ROWS];
	retire_pkg::mem_kind_t row_kind [MAX_ROWS];
	int num_rows;

	// Reference model of the architectural state
	rv_isa_pkg::xlen_t model_regs [32];
	logic [COUNT_WIDTH-1:0] model_retired;
	logic [COUNT_WIDTH-1:0] model_loads;
	logic [COUNT_WIDTH-1:0] model_stores;
	logic [31:0] lfsr_state;

	writeback_top #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) i_dut (
		.clk (clk),
		.rst (rst),
		.advance (advance),
		.in_valid (in_valid),
		.in_pc (in_pc),
		.in_inst (in_inst),
		.in_op_class (in_op_class),
		.in_rd (in_rd),
		.in_wdata (in_wdata),
		.in_raddr (in_raddr),
		.in_waddr (in_waddr),
		.rs1 (rs1),
		.rs2 (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.retire_valid (retire_valid),
		.retire_pc (retire_pc),
		.retire_inst (retire_inst),
		.retire_mem_kind (retire_mem_kind),
		.retire_mem_addr (retire_mem_addr),
		.retire_count (retire_count),
		.load_count (load_count),
		.store_count (store_count)
	);

	always #2 clk = ~clk;

	function automatic rv_isa_pkg::inst_t make_inst(input rv_isa_pkg::funct3_t funct3,
			input rv_isa_pkg::opcode_t opcode, input rv_isa_pkg::reg_id_t rd);
		return {7'b0000000, 5'd2, 5'd1, funct3, rd, opcode}; // rs1 = x1, rs2 = x2
	endfunction

	// Classes 0, 1, 2, 5 and 7 to 11 produce a result for rd
	function automatic logic class_writes_rd(input rv_isa_pkg::op_class_t cls);
		return cls[0] | cls[1] | cls[2] | cls[5] | cls[7] | cls[8] | cls[9] | cls[10] | cls[11];
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [63:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
		end
	endtask

	task automatic add_row(input rv_isa_pkg::inst_t inst, input int cls,
			input rv_isa_pkg::reg_id_t rd, input retire_pkg::mem_kind_t kind);
		row_pc[num_rows] = 64'h0000_0000_8000_0000 + 64'(4 * num_rows);
		row_inst[num_rows] = inst;
		row_class[num_rows] = 15'd1 << cls;
		row_rd[num_rows] = rd;
		row_raddr[num_rows] = 64'h0000_7f00_0000_1000 + 64'(16 * num_rows);
		row_waddr[num_rows] = 64'h0000_3e00_0000_2000 + 64'(24 * num_rows);
		row_kind[num_rows] = kind;
		num_rows++;
	endtask

	task automatic fill_table();
		num_rows = 0;
		for (int f = 0; f < 8; f++) begin
			// funct3 111 is not a legal load width
			add_row(make_inst(3'(f), OPC_LOAD, 5'(f + 1)), 1, 5'(f + 1),
				(f < 7) ? KIND_LOAD : KIND_NONE);
		end
		for (int f = 0; f < 8; f++) begin
			add_row(make_inst(3'(f), OPC_STORE, 5'd9), 3, 5'd9, (f < 4) ? KIND_STORE : KIND_NONE);
		end
		add_row(make_inst(3'd0, OPC_OP, 5'd10), 0, 5'd10, KIND_NONE);
		add_row(make_inst(3'd0, OPC_OP, 5'd0), 0, 5'd0, KIND_NONE); // Write to x0 is dropped
		add_row(make_inst(3'd0, OPC_LUI, 5'd11), 2, 5'd11, KIND_NONE);
		add_row(make_inst(3'd1, OPC_BRANCH, 5'd12), 4, 5'd12, KIND_NONE);
		add_row(make_inst(3'd0, OPC_JAL, 5'd13), 5, 5'd13, KIND_NONE);
		add_row(make_inst(3'd0, OPC_FENCE, 5'd14), 6, 5'd14, KIND_NONE);
		add_row(make_inst(3'd0, OPC_OP, 5'd15), 9, 5'd15, KIND_NONE);
		add_row(make_inst(3'd0, OPC_OP, 5'd16), 13, 5'd16, KIND_NONE);
		add_row(make_inst(3'd0, OPC_OP, 5'd17), 7, 5'd17, KIND_NONE);
		add_row(make_inst(3'd0, OPC_OP, 5'd1), 11, 5'd1, KIND_NONE); // Overwrites x1
	endtask

	task automatic fail_now();
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input string name, input rv_isa_pkg::xlen_t got,
			input rv_isa_pkg::xlen_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_inst(input string name, input rv_isa_pkg::inst_t got,
			input rv_isa_pkg::inst_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_kind(input string name, input retire_pkg::mem_kind_t got,
			input retire_pkg::mem_kind_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] got,
			input logic [COUNT_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	// Read every register through both ports and compare with the model
	task automatic sweep_regs();
		for (int i = 0; i < 32; i++) begin
			@(negedge clk);
			rs1 = 5'(i);
			rs2 = 5'(31 - i);
			#1;
			check_word("rs1_data", rs1_data, model_regs[i]);
			check_word("rs2_data", rs2_data, model_regs[31 - i]);
		end
	endtask

	task automatic run_row(input int idx);
		logic [63:0] bits;
		rv_isa_pkg::xlen_t wdata;
		rv_isa_pkg::xlen_t old_value;
		rv_isa_pkg::xlen_t exp_addr;
		int stall;
		int cycles;
		take_bits(64, bits);
		wdata = bits;
		take_bits(2, bits);
		stall = int'(bits[1:0]);
		take_bits(5, bits);
		rs2 = bits[4:0]; // Random second read port for a spot check
		rs1 = row_rd[idx];
		in_valid = 1'b1;
		advance = 1'b1;
		in_pc = row_pc[idx];
		in_inst = row_inst[idx];
		in_op_class = row_class[idx];
		in_rd = row_rd[idx];
		in_wdata = wdata;
		in_raddr = row_raddr[idx];
		in_waddr = row_waddr[idx];
		old_value = model_regs[row_rd[idx]];
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			in_valid = 1'b0;
			if (cycles > RETIRE_TIMEOUT) begin
				$display("timeout: row %0d never raised retire_valid", idx);
				fail_now();
			end
			if (retire_valid !== 1'b1) begin
				check_word("rs1_data", rs1_data, old_value); // Nothing written before commit
				advance = (cycles <= stall) ? 1'b0 : 1'b1;
			end
		end while (retire_valid !== 1'b1);
		if (cycles != stall + 2) begin
			$display("row %0d retired after %0d cycles instead of %0d", idx, cycles, stall + 2);
			fail_now();
		end
		if (class_writes_rd(row_class[idx]) && row_rd[idx] != 5'd0) begin
			model_regs[row_rd[idx]] = wdata;
		end
		model_retired = model_retired + COUNT_WIDTH'(1);
		case (row_kind[idx])
			KIND_LOAD: begin
				exp_addr = row_raddr[idx];
				model_loads = model_loads + COUNT_WIDTH'(1);
			end
			KIND_STORE: begin
				exp_addr = row_waddr[idx];
				model_stores = model_stores + COUNT_WIDTH'(1);
			end
			default: exp_addr = '0;
		endcase
		check_word("retire_pc", retire_pc, row_pc[idx]);
		check_inst("retire_inst", retire_inst, row_inst[idx]);
		check_kind("retire_mem_kind", retire_mem_kind, row_kind[idx]);
		check_word("retire_mem_addr", retire_mem_addr, exp_addr);
		check_count("retire_count", retire_count, model_retired);
		check_count("load_count", load_count, model_loads);
		check_count("store_count", store_count, model_stores);
		check_word("rs1_data", rs1_data, model_regs[rs1]);
		check_word("rs2_data", rs2_data, model_regs[rs2]);
	endtask

	initial begin
		rst = 1'b1;
		advance = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_inst = '0;
		in_op_class = '0;
		in_rd = '0;
		in_wdata = '0;
		in_raddr = '0;
		in_waddr = '0;
		rs1 = '0;
		rs2 = '0;
		lfsr_state = LFSR_SEED;
		model_retired = '0;
		model_loads = '0;
		model_stores = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		fill_table();

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		if (retire_valid !== 1'b0) begin
			$display("retire_valid is high right after reset");
			fail_now();
		end
		check_count("retire_count", retire_count, '0);
		check_count("load_count", load_count, '0);
		check_count("store_count", store_count, '0);
		sweep_regs();

		@(negedge clk);
		for (int idx = 0; idx < num_rows; idx++) begin
			run_row(idx); // Next row enters while this record is still on the outputs
		end
		@(negedge clk);
		if (retire_valid !== 1'b0) begin
			$display("retire_valid stayed high after the last record");
			fail_now();
		end
		check_count("retire_count", retire_count, COUNT_WIDTH'(num_rows));
		sweep_regs();

		@(negedge clk);
		if (i_dut.i_writeback_assertions.assert_failures == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("%0d concurrent assertions failed",
				i_dut.i_writeback_assertions.assert_failures);
			fail_now();
		end
	end

endmodule

`default_nettype wire

//--- writeback.f
hw/rv_isa_pkg.sv
hw/retire_pkg.sv
hw/wb_stage.sv
hw/gpr_file.sv
hw/retire_monitor.sv
hw/writeback_top.sv
test/writeback_assertions.sv
test/writeback_tb.sv

//--- Makefile
# Verilator build and run for the writeback testbench

VERILATOR ?= verilator
TOP ?= writeback_tb
FILELIST ?= writeback.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
